// ==== common/apb_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared widths, counts and address map of the APB subsystem
// Interconnect state encoding
////////////////////////////////////////////////////////////

package apb_pkg;

    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 16;

    // Port counts and index widths
    localparam int NUM_MASTERS = 3;
    localparam int NUM_SLAVES  = 4;
    localparam int MST_IDX_W   = 2;
    localparam int SLV_IDX_W   = 2;

    // Words per register bank, offset is addr[2:0]
    localparam int REG_WORDS = 8;

    // Address map, one window of REG_WORDS per slave
    localparam logic [NUM_SLAVES-1:0][ADDR_W-1:0] SLV_BASE = {
        16'h1030,
        16'h1020,
        16'h1010,
        16'h1000
    };

    localparam logic [NUM_SLAVES-1:0][ADDR_W-1:0] SLV_END = {
        16'h1037,
        16'h1027,
        16'h1017,
        16'h1007
    };

    // Phases of the shared slave bus
    typedef enum logic [1:0] {
        BUS_IDLE   = 2'd0,
        BUS_SETUP  = 2'd1,
        BUS_ACCESS = 2'd2
    } bus_state_e;

endpackage

// ==== intercon/addr_dec.sv ====
////////////////////////////////////////////////////////////
// Address decoder, one-hot slave select and binary index
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module addr_dec (
    input  logic [apb_pkg::ADDR_W-1:0]     addr,
    output logic [apb_pkg::NUM_SLAVES-1:0] sel,
    output logic [apb_pkg::SLV_IDX_W-1:0]  seli
);

    // Range compare against each window of the map
    genvar gi;
    generate
        for (gi = 0; gi < apb_pkg::NUM_SLAVES; gi++) begin : g_range
            assign sel[gi] = (addr >= apb_pkg::SLV_BASE[gi])
                          && (addr <= apb_pkg::SLV_END[gi]);
        end
    endgenerate

    // Lowest matching slave wins, 0 when unmapped
    always_comb begin
        seli = '0;
        for (int i = apb_pkg::NUM_SLAVES - 1; i >= 0; i--) begin
            if (sel[i]) begin
                seli = i[apb_pkg::SLV_IDX_W-1:0];
            end
        end
    end

endmodule

// ==== intercon/arbiter.sv ====
////////////////////////////////////////////////////////////
// Round-robin arbiter with a rotating one-hot token
// Grant, select and active are registered
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module arbiter #(
    parameter int NUM_PORTS = 3
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [NUM_PORTS-1:0]         request,
    output logic [NUM_PORTS-1:0]         grant,
    output logic [$clog2(NUM_PORTS)-1:0] select,
    output logic                         active
);

    logic [NUM_PORTS-1:0]   token;
    logic [NUM_PORTS-1:0]   token_next;
    logic [NUM_PORTS-1:0]   cand;
    logic [2*NUM_PORTS-1:0] token_wrap;
    logic                   found;
    logic                   owner_req;

    assign token_wrap = {token, token};
    assign owner_req  = |(token & request);

    // Lookahead: nearest requester after the owner, in rotation order
    always_comb begin
        token_next = token;
        cand       = token;
        found      = 1'b0;
        for (int k = 1; k < NUM_PORTS; k++) begin
            cand = token_wrap[NUM_PORTS-k +: NUM_PORTS];
            if (!found && |(cand & request)) begin
                token_next = cand;
                found      = 1'b1;
            end
        end
    end

    // Token only moves once its owner lets go
    always_ff @(posedge clk) begin
        if (rst) begin
            token <= {{(NUM_PORTS-1){1'b0}}, 1'b1};
        end else if (!owner_req) begin
            token <= token_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant  <= '0;
            select <= '0;
            active <= 1'b0;
        end else begin
            grant  <= token & request;
            active <= owner_req;
            select <= '0;
            for (int i = NUM_PORTS - 1; i >= 0; i--) begin
                if (token[i] & request[i]) begin
                    select <= i[$clog2(NUM_PORTS)-1:0];
                end
            end
        end
    end

endmodule

// ==== intercon/apb_intercon.sv ====
////////////////////////////////////////////////////////////
// APB interconnect: arbitration between masters, phase
// sequencing on the shared slave bus, response routing
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apb_intercon (
    input  logic                                            clk,
    input  logic                                            rst,
    // Master side, one lane per master
    input  logic [apb_pkg::NUM_MASTERS*apb_pkg::ADDR_W-1:0] s_paddr,
    input  logic [apb_pkg::NUM_MASTERS-1:0]                 s_pwrite,
    input  logic [apb_pkg::NUM_MASTERS-1:0]                 s_psel,
    input  logic [apb_pkg::NUM_MASTERS-1:0]                 s_penable,
    input  logic [apb_pkg::NUM_MASTERS*apb_pkg::DATA_W-1:0] s_pwdata,
    output logic [apb_pkg::NUM_MASTERS*apb_pkg::DATA_W-1:0] s_prdata,
    output logic [apb_pkg::NUM_MASTERS-1:0]                 s_pready,
    // Shared slave bus
    output logic [apb_pkg::ADDR_W-1:0]                      m_paddr,
    output logic                                            m_pwrite,
    output logic [apb_pkg::NUM_SLAVES-1:0]                  m_psel,
    output logic                                            m_penable,
    output logic [apb_pkg::DATA_W-1:0]                      m_pwdata,
    // Response from the slave side
    input  logic [apb_pkg::DATA_W-1:0]                      bus_prdata,
    input  logic                                            bus_pready
);

    apb_pkg::bus_state_e state;

    logic [apb_pkg::MST_IDX_W-1:0]   act_mst;
    logic [apb_pkg::NUM_MASTERS-1:0] act_grant;
    logic [apb_pkg::NUM_MASTERS-1:0] arb_req;
    logic [apb_pkg::NUM_MASTERS-1:0] arb_grant;
    logic [apb_pkg::MST_IDX_W-1:0]   arb_select;
    logic                            arb_active;
    logic [apb_pkg::NUM_SLAVES-1:0]  dec_sel;
    logic                            done;

    assign done = (state == apb_pkg::BUS_ACCESS) && bus_pready;

    // Hide the finishing master for one cycle so the token moves on
    assign arb_req = s_psel & ~(act_grant & {apb_pkg::NUM_MASTERS{done}});

    arbiter #(
        .NUM_PORTS (apb_pkg::NUM_MASTERS)
    ) u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .request   (arb_req),
        .grant     (arb_grant),
        .select    (arb_select),
        .active    (arb_active)
    );

    // Forward the active master's request fields
    assign m_paddr  = s_paddr[act_mst*apb_pkg::ADDR_W +: apb_pkg::ADDR_W];
    assign m_pwrite = s_pwrite[act_mst];
    assign m_pwdata = s_pwdata[act_mst*apb_pkg::DATA_W +: apb_pkg::DATA_W];

    addr_dec u_addr_dec (
        .addr      (m_paddr),
        .sel       (dec_sel),
        .seli      ()
    );

    assign m_psel    = (state != apb_pkg::BUS_IDLE) ? dec_sel : '0;
    assign m_penable = (state == apb_pkg::BUS_ACCESS);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= apb_pkg::BUS_IDLE;
            act_mst   <= '0;
            act_grant <= '0;
        end else begin
            case (state)
                apb_pkg::BUS_IDLE: begin
                    if (arb_active) begin
                        act_mst   <= arb_select;
                        act_grant <= arb_grant;
                        state     <= apb_pkg::BUS_SETUP;
                    end
                end
                apb_pkg::BUS_SETUP: begin
                    // Master must be in its own access phase
                    if (s_penable[act_mst]) begin
                        state <= apb_pkg::BUS_ACCESS;
                    end
                end
                apb_pkg::BUS_ACCESS: begin
                    if (bus_pready) begin
                        state <= apb_pkg::BUS_IDLE;
                    end
                end
                default: state <= apb_pkg::BUS_IDLE;
            endcase
        end
    end

    // Response goes to the active lane only, others stay 0
    always_comb begin
        s_pready = '0;
        s_prdata = '0;
        for (int i = 0; i < apb_pkg::NUM_MASTERS; i++) begin
            if (act_grant[i] && state == apb_pkg::BUS_ACCESS) begin
                s_pready[i]                                  = bus_pready;
                s_prdata[i*apb_pkg::DATA_W +: apb_pkg::DATA_W] = bus_prdata;
            end
        end
    end

endmodule

// ==== verilog/apb_regs.sv ====
////////////////////////////////////////////////////////////
// APB register bank slave, one wait state per access
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apb_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [apb_pkg::ADDR_W-1:0] paddr,
    input  logic [apb_pkg::DATA_W-1:0] pwdata,
    output logic [apb_pkg::DATA_W-1:0] prdata,
    output logic                       pready
);

    logic [apb_pkg::DATA_W-1:0] mem [apb_pkg::REG_WORDS];
    logic [$clog2(apb_pkg::REG_WORDS)-1:0] idx;
    logic access;
    logic wait_q;

    assign idx    = paddr[$clog2(apb_pkg::REG_WORDS)-1:0];
    assign access = psel & penable;

    // Set after the first access cycle, cleared on completion
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= access & ~wait_q;
        end
    end

    assign pready = access & wait_q;
    assign prdata = mem[idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < apb_pkg::REG_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (pready && pwrite) begin
            mem[idx] <= pwdata;
        end
    end

endmodule

// ==== verilog/apb_resp_mux.sv ====
////////////////////////////////////////////////////////////
// Slave response mux, unmapped accesses finish with data 0
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apb_resp_mux (
    input  logic [apb_pkg::NUM_SLAVES-1:0]                 sel,
    input  logic                                           penable,
    input  logic [apb_pkg::NUM_SLAVES*apb_pkg::DATA_W-1:0] slv_prdata,
    input  logic [apb_pkg::NUM_SLAVES-1:0]                 slv_pready,
    output logic [apb_pkg::DATA_W-1:0]                     bus_prdata,
    output logic                                           bus_pready
);

    logic unmapped;

    // No slave selected while the bus is in access
    assign unmapped = penable & ~|sel;

    always_comb begin
        bus_prdata = '0;
        for (int i = 0; i < apb_pkg::NUM_SLAVES; i++) begin
            if (sel[i]) begin
                bus_prdata = bus_prdata
                           | slv_prdata[i*apb_pkg::DATA_W +: apb_pkg::DATA_W];
            end
        end
    end

    assign bus_pready = |(sel & slv_pready) | unmapped;

endmodule

// ==== verilog/apb_subsys.sv ====
////////////////////////////////////////////////////////////
// APB subsystem top: interconnect, register-bank slaves and
// the response mux
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apb_subsys (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [apb_pkg::NUM_MASTERS*apb_pkg::ADDR_W-1:0] s_paddr,
    input  logic [apb_pkg::NUM_MASTERS-1:0]                 s_pwrite,
    input  logic [apb_pkg::NUM_MASTERS-1:0]                 s_psel,
    input  logic [apb_pkg::NUM_MASTERS-1:0]                 s_penable,
    input  logic [apb_pkg::NUM_MASTERS*apb_pkg::DATA_W-1:0] s_pwdata,
    output logic [apb_pkg::NUM_MASTERS*apb_pkg::DATA_W-1:0] s_prdata,
    output logic [apb_pkg::NUM_MASTERS-1:0]                 s_pready
);

    // Shared slave bus
    logic [apb_pkg::ADDR_W-1:0]     m_paddr;
    logic                           m_pwrite;
    logic [apb_pkg::NUM_SLAVES-1:0] m_psel;
    logic                           m_penable;
    logic [apb_pkg::DATA_W-1:0]     m_pwdata;

    // Per-slave responses and the merged response
    logic [apb_pkg::NUM_SLAVES*apb_pkg::DATA_W-1:0] slv_prdata;
    logic [apb_pkg::NUM_SLAVES-1:0]                 slv_pready;
    logic [apb_pkg::DATA_W-1:0]                     bus_prdata;
    logic                                           bus_pready;

    apb_intercon u_apb_intercon (
        .clk        (clk),
        .rst        (rst),
        .s_paddr    (s_paddr),
        .s_pwrite   (s_pwrite),
        .s_psel     (s_psel),
        .s_penable  (s_penable),
        .s_pwdata   (s_pwdata),
        .s_prdata   (s_prdata),
        .s_pready   (s_pready),
        .m_paddr    (m_paddr),
        .m_pwrite   (m_pwrite),
        .m_psel     (m_psel),
        .m_penable  (m_penable),
        .m_pwdata   (m_pwdata),
        .bus_prdata (bus_prdata),
        .bus_pready (bus_pready)
    );

    genvar gi;
    generate
        for (gi = 0; gi < apb_pkg::NUM_SLAVES; gi++) begin : g_slv
            apb_regs u_apb_regs (
                .clk     (clk),
                .rst     (rst),
                .psel    (m_psel[gi]),
                .penable (m_penable),
                .pwrite  (m_pwrite),
                .paddr   (m_paddr),
                .pwdata  (m_pwdata),
                .prdata  (slv_prdata[gi*apb_pkg::DATA_W +: apb_pkg::DATA_W]),
                .pready  (slv_pready[gi])
            );
        end
    endgenerate

    apb_resp_mux u_apb_resp_mux (
        .sel        (m_psel),
        .penable    (m_penable),
        .slv_prdata (slv_prdata),
        .slv_pready (slv_pready),
        .bus_prdata (bus_prdata),
        .bus_pready (bus_pready)
    );

endmodule

// ==== bench/tb_clock.sv ====
////////////////////////////////////////////////////////////
// Free-running testbench clock
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// ==== bench/apb_subsys_assert.sv ====
////////////////////////////////////////////////////////////
// Protocol assertions on the APB subsystem, bound to its top
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apb_subsys_assert (
    input logic                            clk,
    input logic                            rst,
    input logic [apb_pkg::NUM_MASTERS-1:0] s_psel,
    input logic [apb_pkg::NUM_MASTERS-1:0] s_penable,
    input logic [apb_pkg::NUM_MASTERS-1:0] s_pready,
    input logic [apb_pkg::NUM_SLAVES-1:0]  m_psel,
    input logic                            m_penable,
    input logic                            bus_pready
);

    // Ready only for a lane in its access phase
    a_ready_lane: assert property (@(posedge clk) disable iff (rst)
        (s_pready & ~(s_psel & s_penable)) == '0)
        else $error("s_pready high on a lane outside its access phase");

    a_psel_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(m_psel))
        else $error("m_psel has more than one bit set");

    // Access starts after a setup with the same select
    a_enable_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(m_penable) |-> ($past(m_psel) == m_psel) && $past(|s_psel))
        else $error("m_penable rose without a setup phase");

    // A finished access does not continue
    a_enable_hold: assert property (@(posedge clk) disable iff (rst)
        m_penable |-> !$past(m_penable && bus_pready))
        else $error("m_penable stayed high after a completed access");

    a_reset_quiet: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (s_pready == '0) && (m_psel == '0) && !m_penable)
        else $error("ready or select output high during reset");

endmodule

bind apb_subsys apb_subsys_assert u_apb_subsys_assert (
    .clk        (clk),
    .rst        (rst),
    .s_psel     (s_psel),
    .s_penable  (s_penable),
    .s_pready   (s_pready),
    .m_psel     (m_psel),
    .m_penable  (m_penable),
    .bus_pready (bus_pready)
);

// ==== bench/apb_subsys_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the APB subsystem: master transfers, shadow
// memory, fairness checks, watchdog and summary
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apb_subsys_tb;

    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int NM              = apb_pkg::NUM_MASTERS;
    localparam int AW              = apb_pkg::ADDR_W;
    localparam int DW              = apb_pkg::DATA_W;

    logic                 clk;
    logic                 rst;
    logic [NM*AW-1:0]     s_paddr;
    logic [NM-1:0]        s_pwrite;
    logic [NM-1:0]        s_psel;
    logic [NM-1:0]        s_penable;
    logic [NM*DW-1:0]     s_pwdata;
    logic [NM*DW-1:0]     s_prdata;
    logic [NM-1:0]        s_pready;

    // Per-master request state, packed onto the DUT lanes
    logic [AW-1:0] addr_q    [NM];
    logic [DW-1:0] pwdata_q  [NM];
    logic          pwrite_q  [NM];
    logic          psel_q    [NM];
    logic          penable_q [NM];

    logic [DW-1:0] shadow [4][8];
    bit            busy   [NM];
    bit            hold   [NM];
    time           pend_t [NM];
    time           done_t [NM];

    int errors;
    int checks;
    int tests_run;
    int errs_start;

    tb_clock #(.PERIOD_NS(8)) u_tb_clock (.clk(clk));

    apb_subsys u_apb_subsys (
        .clk       (clk),
        .rst       (rst),
        .s_paddr   (s_paddr),
        .s_pwrite  (s_pwrite),
        .s_psel    (s_psel),
        .s_penable (s_penable),
        .s_pwdata  (s_pwdata),
        .s_prdata  (s_prdata),
        .s_pready  (s_pready)
    );

    genvar gi;
    generate
        for (gi = 0; gi < NM; gi++) begin : g_lane
            assign s_paddr[gi*AW +: AW]  = addr_q[gi];
            assign s_pwdata[gi*DW +: DW] = pwdata_q[gi];
            assign s_pwrite[gi]          = pwrite_q[gi];
            assign s_psel[gi]            = psel_q[gi];
            assign s_penable[gi]         = penable_q[gi];
        end
    endgenerate

    // Slaves sit at 0x1000 with a 16-byte stride
    function automatic logic [AW-1:0] reg_addr(input int s, input int off);
        return 16'(16'h1000 + s * 16 + off);
    endfunction

    task automatic check_value(input string name, input logic [DW-1:0] exp,
                               input logic [DW-1:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // One APB transfer on lane m, returns the read data
    task automatic transfer(input int m, input logic wr, input logic [AW-1:0] addr,
                            input logic [DW-1:0] wdata, output logic [DW-1:0] rdata);
        @(negedge clk);
        addr_q[m]    = addr;
        pwrite_q[m]  = wr;
        pwdata_q[m]  = wdata;
        psel_q[m]    = 1'b1;
        penable_q[m] = 1'b0;
        busy[m]      = 1'b1;
        pend_t[m]    = $time;
        @(negedge clk);
        penable_q[m] = 1'b1;
        do @(negedge clk); while (!s_pready[m]);
        rdata = s_prdata[m*DW +: DW];
        // Nobody waiting since before our last completion
        for (int j = 0; j < NM; j++) begin
            if (j != m && busy[j]) begin
                checks++;
                assert (pend_t[j] >= done_t[m]) else begin
                    $display("Master %0d completed twice while master %0d waited", m, j);
                    errors++;
                end
            end
        end
        done_t[m] = $time;
        busy[m]   = 1'b0;
        // A held lane goes straight into its next setup
        if (!hold[m]) begin
            @(negedge clk);
            psel_q[m]    = 1'b0;
            penable_q[m] = 1'b0;
        end
    endtask

    task automatic write_word(input int m, input int s, input int off,
                              input logic [DW-1:0] data);
        logic [DW-1:0] rd;
        transfer(m, 1'b1, reg_addr(s, off), data, rd);
        shadow[s][off] = data;
    endtask

    task automatic read_check(input int m, input int s, input int off);
        logic [DW-1:0] rd;
        transfer(m, 1'b0, reg_addr(s, off), '0, rd);
        check_value("s_prdata", shadow[s][off], rd);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name,
                 (errors == errs_start) ? "ok" : "errors");
        errs_start = errors;
    endtask

    task automatic random_traffic(input int m);
        int s;
        int off;
        for (int k = 0; k < 6; k++) begin
            s   = $urandom % 4;
            off = m + 3 * ($urandom % 2);
            if ($urandom % 2) begin
                write_word(m, s, off, 16'($urandom));
            end else begin
                read_check(m, s, off);
            end
        end
    endtask

    initial begin
        logic [DW-1:0] rd;
        logic [AW-1:0] bad [4];
        int off;
        void'($urandom(40));
        rst = 1'b1;
        for (int m = 0; m < NM; m++) begin
            addr_q[m]    = '0;
            pwdata_q[m]  = '0;
            pwrite_q[m]  = 1'b0;
            psel_q[m]    = 1'b0;
            penable_q[m] = 1'b0;
            busy[m]      = 1'b0;
            hold[m]      = 1'b0;
            pend_t[m]    = 0;
            done_t[m]    = 0;
        end
        for (int s = 0; s < 4; s++) begin
            for (int w = 0; w < 8; w++) begin
                shadow[s][w] = '0;
            end
        end
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        errs_start = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int s = 0; s < 4; s++) begin
            for (int w = 0; w < 8; w++) begin
                read_check((s * 8 + w) % NM, s, w);
            end
        end
        end_test("reset values");

        // Same offset in every slave with distinct data
        for (int r = 0; r < 2; r++) begin
            off = $urandom % 8;
            for (int s = 0; s < 4; s++) begin
                write_word(s % NM, s, off, 16'($urandom) ^ 16'(s << 12));
            end
            for (int s = 0; s < 4; s++) begin
                read_check((s + 1) % NM, s, off);
            end
        end
        end_test("write and readback");

        bad[0] = 16'h1008;
        bad[1] = 16'h0000;
        bad[2] = 16'h2003;
        bad[3] = 16'h103f;
        for (int i = 0; i < 4; i++) begin
            transfer(i % NM, 1'b1, bad[i], 16'hdead, rd);
            transfer(i % NM, 1'b0, bad[i], '0, rd);
            check_value("s_prdata", '0, rd);
        end
        for (int s = 0; s < 4; s++) begin
            read_check(0, s, 0);
            read_check(1, s, 3);
            read_check(2, s, 7);
        end
        end_test("unmapped addresses");

        fork
            begin
                write_word(0, 0, 0, 16'h0a0a);
                read_check(0, 0, 0);
            end
            begin
                write_word(1, 1, 1, 16'h1b1b);
                read_check(1, 1, 1);
            end
            begin
                write_word(2, 2, 2, 16'h2c2c);
                read_check(2, 2, 2);
            end
        join
        end_test("concurrent masters");

        // Master 0 keeps psel up across its transfers, master 1 competes
        fork
            begin
                for (int k = 0; k < 4; k++) begin
                    hold[0] = (k < 3);
                    write_word(0, 0, 4 + k, 16'(16'h5000 + k));
                end
            end
            begin
                for (int k = 0; k < 4; k++) begin
                    write_word(1, 1, 4 + k, 16'(16'h6000 + k));
                end
            end
        join
        end_test("round-robin fairness");

        fork
            random_traffic(0);
            random_traffic(1);
            random_traffic(2);
        join
        for (int s = 0; s < 4; s++) begin
            for (int w = 0; w < 8; w++) begin
                read_check(0, s, w);
            end
        end
        end_test("random traffic");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (16 + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Timeout: the tests did not finish within the cycle limit");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
common/apb_pkg.sv
intercon/addr_dec.sv
intercon/arbiter.sv
intercon/apb_intercon.sv
verilog/apb_regs.sv
verilog/apb_resp_mux.sv
verilog/apb_subsys.sv
bench/tb_clock.sv
bench/apb_subsys_assert.sv
bench/apb_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module apb_subsys_tb -o sim_apb \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_apb > sim.log 2>&1 ; cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
